// File: clint_cases.txt
# kind addr data exp slack, hex; W write, R read, I irq level in exp, T time_hi_o in exp
# D waits data idle cycles, then reads mtime low and checks its rise since the last read
R 0200000C 00000000 00000000 0
R 02000008 00000000 00000000 0
I 00000000 00000000 00000001 0
W 0200000C 00000001 00000000 0
I 00000000 00000000 00000000 0
W 02000008 A5A51234 00000000 0
R 02000008 00000000 A5A51234 0
R 0200000C 00000000 00000001 0
W 0200000C 5C3E9F01 00000000 0
R 02000008 00000000 A5A51234 0
R 0200000C 00000000 5C3E9F01 0
W 02000004 00000010 00000000 0
R 02000004 00000000 00000010 0
W 02000000 10000000 00000000 0
R 02000000 00000000 10000000 1
T 02000000 00000000 00000010 1
D 02000000 00000280 0000000A 1
D 02000000 00000100 00000004 1
I 00000000 00000000 00000000 0
W 0200000C 00000010 00000000 0
I 00000000 00000000 00000000 0
W 02000008 00000100 00000000 0
I 00000000 00000000 00000001 0
R 03000000 00000000 00000000 0
W 03000008 FFFFFFFF 00000000 0
W 02000002 DEADBEEF 00000000 0
R 02000002 00000000 00000000 0
R 02000008 00000000 00000100 0
R 0200000C 00000000 00000010 0
R 02000004 00000000 00000010 0

// File: sources.f
+incdir+.
clint_pkg.sv
timer_prescaler.sv
clint.sv
dbus_periph_decoder.sv
periph_subsys_top.sv
tb_clk_gen.sv
tb_periph_subsys.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module tb_periph_subsys \
    -f sources.f -o tb_periph_subsys > build.log 2>&1 \
    && ./obj_dir/tb_periph_subsys > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// File: tb_periph_subsys.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps
`include "clint_defs.svh"

module tb_periph_subsys;

    import clint_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int CASE_CYCLES   = 16;
    localparam int MAX_CASES     = 64;

    logic             clk;
    logic             rst_n;
    logic             dbus_cyc;
    logic             dbus_w_en;
    type_dbus_addr_u  dbus_addr;
    logic [`XLEN-1:0] dbus_w_data;
    logic             dbus_ack;
    logic [`XLEN-1:0] dbus_r_data;
    logic [`XLEN-1:0] time_lo;
    logic [`XLEN-1:0] time_hi;
    logic             timer_irq;

    // Case table, one entry per line of the case file
    logic [7:0]       kind_q [MAX_CASES];
    logic [31:0]      addr_q [MAX_CASES];
    logic [`XLEN-1:0] data_q [MAX_CASES];
    logic [`XLEN-1:0] exp_q [MAX_CASES];
    logic [`XLEN-1:0] slack_q [MAX_CASES];
    int               n_cases;
    int               pass_cnt;
    int               fail_cnt;
    // Last bus-read value of mtime low, base for the rise checks
    logic [`XLEN-1:0] last_lo;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    periph_subsys_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .dbus_cyc_i    (dbus_cyc),
        .dbus_w_en_i   (dbus_w_en),
        .dbus_addr_i   (dbus_addr),
        .dbus_w_data_i (dbus_w_data),
        .dbus_ack_o    (dbus_ack),
        .dbus_r_data_o (dbus_r_data),
        .time_lo_o     (time_lo),
        .time_hi_o     (time_hi),
        .timer_irq_o   (timer_irq)
    );

    // --------------------
    // Compare tasks
    // --------------------

    // Pass when got lies in exp .. exp+slack
    task automatic check_r_data(input int idx, input string sig_name,
                                input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                                input logic [`XLEN-1:0] slack);
        if (got - exp <= slack) begin
            pass_cnt++;
            $display("case %0d %s ok 0x%08h", idx, sig_name, got);
        end else begin
            fail_cnt++;
            $display("error case %0d %s got 0x%08h exp 0x%08h slack 0x%0h",
                     idx, sig_name, got, exp, slack);
        end
    endtask

    task automatic check_irq(input int idx, input logic got, input logic exp);
        if (got === exp) begin
            pass_cnt++;
            $display("case %0d timer_irq_o ok 0x%0h", idx, got);
        end else begin
            fail_cnt++;
            $display("error case %0d timer_irq_o got 0x%0h exp 0x%0h", idx, got, exp);
        end
    endtask

    task automatic check_time(input int idx, input logic [`XLEN-1:0] got_lo,
                              input logic [`XLEN-1:0] got_hi, input logic [`XLEN-1:0] exp_lo,
                              input logic [`XLEN-1:0] exp_hi, input logic [`XLEN-1:0] slack);
        if ((got_lo - exp_lo <= slack) && (got_hi - exp_hi <= slack)) begin
            pass_cnt++;
            $display("case %0d time_hi_o time_lo_o ok 0x%08h 0x%08h", idx, got_hi, got_lo);
        end else begin
            fail_cnt++;
            $display("error case %0d time_lo_o got 0x%08h exp 0x%08h time_hi_o got 0x%08h exp 0x%08h",
                     idx, got_lo, exp_lo, got_hi, exp_hi);
        end
    endtask

    // --------------------
    // Bus driver
    // --------------------

    // Drive on the falling edge, ack sampled on later falling edges
    task automatic bus_access(input int idx, input logic w_en, input logic [31:0] addr,
                              input logic [`XLEN-1:0] w_data,
                              output logic [`XLEN-1:0] r_data, output logic acked);
        int wait_cnt;
        @(negedge clk);
        dbus_cyc       = 1'b1;
        dbus_w_en      = w_en;
        dbus_addr.word = addr;
        dbus_w_data    = w_data;
        acked          = 1'b0;
        r_data         = '0;
        wait_cnt       = 0;
        while (!acked && wait_cnt < 2) begin
            @(negedge clk);
            wait_cnt++;
            if (dbus_ack) begin
                acked  = 1'b1;
                r_data = dbus_r_data;
            end
        end
        dbus_cyc  = 1'b0;
        dbus_w_en = 1'b0;
        if (!acked) begin
            fail_cnt++;
            $display("case %0d got no ack within 2 cycles of the request", idx);
        end
    endtask

    // --------------------
    // Case file and watchdog
    // --------------------

    task automatic load_cases();
        int    fd;
        string line;
        n_cases = 0;
        fd = $fopen("clint_cases.txt", "r");
        if (fd == 0) begin
            fail_cnt++;
            $display("cannot open clint_cases.txt, no cases run");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%c %h %h %h %h", kind_q[n_cases], addr_q[n_cases],
                                data_q[n_cases], exp_q[n_cases], slack_q[n_cases]) == 5) begin
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Budget of 16 cycles per case plus the idle cycles of rise cases
    task automatic run_watchdog();
        int budget;
        budget = RESET_CYCLES;
        for (int i = 0; i < n_cases; i++) begin
            budget += CASE_CYCLES;
            if (kind_q[i] == "D") begin
                budget += int'(data_q[i]);
            end
        end
        #(budget * CLK_PERIOD_NS);
        $display("timeout, the run did not finish within %0d cycles", budget);
        $display(">>> FAIL");
        $finish;
    endtask

    // --------------------
    // Case runner
    // --------------------

    task automatic run_case(input int idx);
        logic [`XLEN-1:0] r_data;
        logic             acked;
        logic             irq;
        repeat ($urandom_range(3, 0)) @(negedge clk);
        case (kind_q[idx])
            "W": begin
                bus_access(idx, 1'b1, addr_q[idx], data_q[idx], r_data, acked);
                // Write acks carry zero data
                if (acked) begin
                    check_r_data(idx, "dbus_r_data_o", r_data, '0, '0);
                end
            end
            "R", "D", "T": begin
                // Rise cases wait the idle count from the data column
                if (kind_q[idx] == "D") begin
                    repeat (data_q[idx]) @(negedge clk);
                end
                bus_access(idx, 1'b0, addr_q[idx], '0, r_data, acked);
                if (acked && kind_q[idx] == "R") begin
                    check_r_data(idx, "dbus_r_data_o", r_data, exp_q[idx], slack_q[idx]);
                end else if (acked && kind_q[idx] == "D") begin
                    check_r_data(idx, "dbus_r_data_o rise", r_data - last_lo, exp_q[idx],
                                 slack_q[idx]);
                end else if (acked) begin
                    check_time(idx, time_lo, time_hi, r_data, exp_q[idx], slack_q[idx]);
                end
                if (acked && addr_q[idx] == {`REGION_CLINT, MTIME_LOW_R}) begin
                    last_lo = r_data;
                end
            end
            "I": begin
                // Interrupt may take up to 2 cycles to settle
                irq = timer_irq;
                for (int k = 0; k < 3 && irq !== exp_q[idx][0]; k++) begin
                    @(negedge clk);
                    irq = timer_irq;
                end
                check_irq(idx, irq, exp_q[idx][0]);
            end
            default: begin
                fail_cnt++;
                $display("case %0d has an unknown operation kind", idx);
            end
        endcase
    endtask

    initial begin
        dbus_cyc    = 1'b0;
        dbus_w_en   = 1'b0;
        dbus_addr   = '0;
        dbus_w_data = '0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        last_lo     = '0;
        load_cases();
        fork
            run_watchdog();
        join_none
        @(posedge rst_n);
        void'($urandom(32'hd59c_18d7));
        for (int idx = 0; idx < n_cases; idx++) begin
            run_case(idx);
        end
        $display("cases %0d passed %0d failed %0d", n_cases, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && n_cases > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Clock starts low, reset released on the 4th falling edge
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        #(4 * PERIOD_NS) rst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: periph_subsys_top.sv
// Peripheral subsystem top
`timescale 1ns/1ps
`include "clint_defs.svh"

module periph_subsys_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dbus_cyc_i,
    input  logic                       dbus_w_en_i,
    input  clint_pkg::type_dbus_addr_u dbus_addr_i,
    input  logic [`XLEN-1:0]           dbus_w_data_i,
    output logic                       dbus_ack_o,
    output logic [`XLEN-1:0]           dbus_r_data_o,
    output logic [`XLEN-1:0]           time_lo_o,
    output logic [`XLEN-1:0]           time_hi_o,
    output logic                       timer_irq_o
);

    // --------------------
    // Internal wiring
    // --------------------

    logic             clint_sel;
    logic             clint_ack;
    logic [`XLEN-1:0] clint_r_data;
    logic             time_tick;

    // Address decode and response merge
    dbus_periph_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .dbus_cyc_i     (dbus_cyc_i),
        .dbus_addr_i    (dbus_addr_i),
        .clint_sel_o    (clint_sel),
        .clint_ack_i    (clint_ack),
        .clint_r_data_i (clint_r_data),
        .dbus_ack_o     (dbus_ack_o),
        .dbus_r_data_o  (dbus_r_data_o)
    );

    // mtime clock enable
    timer_prescaler u_prescaler (
        .clk         (clk),
        .rst_n       (rst_n),
        .time_tick_o (time_tick)
    );

    // Timer registers and interrupt
    clint u_clint (
        .clk            (clk),
        .rst_n          (rst_n),
        .clint_sel_i    (clint_sel),
        .dbus_cyc_i     (dbus_cyc_i),
        .dbus_w_en_i    (dbus_w_en_i),
        .dbus_addr_i    (dbus_addr_i),
        .dbus_w_data_i  (dbus_w_data_i),
        .time_tick_i    (time_tick),
        .clint_ack_o    (clint_ack),
        .clint_r_data_o (clint_r_data),
        .time_lo_o      (time_lo_o),
        .time_hi_o      (time_hi_o),
        .timer_irq_o    (timer_irq_o)
    );

endmodule

// File: dbus_periph_decoder.sv
// Data-bus peripheral decoder
`timescale 1ns/1ps
`include "clint_defs.svh"

module dbus_periph_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dbus_cyc_i,
    input  clint_pkg::type_dbus_addr_u dbus_addr_i,
    output logic                       clint_sel_o,
    input  logic                       clint_ack_i,
    input  logic [`XLEN-1:0]           clint_r_data_i,
    output logic                       dbus_ack_o,
    output logic [`XLEN-1:0]           dbus_r_data_o
);

    logic unmapped_req;
    logic unmapped_ack_q;

    // --------------------
    // Region decode
    // --------------------

    // Region view of the address union
    assign clint_sel_o  = (dbus_addr_i.field.region == `REGION_CLINT);
    assign unmapped_req = dbus_cyc_i && !clint_sel_o;

    // Unmapped responder, single pulse one clock after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unmapped_ack_q <= 1'b0;
        end else begin
            unmapped_ack_q <= unmapped_req && !unmapped_ack_q;
        end
    end

    // --------------------
    // Response merge
    // --------------------

    assign dbus_ack_o = clint_ack_i || unmapped_ack_q;

    // Unmapped ack returns zero data
    assign dbus_r_data_o = clint_ack_i ? clint_r_data_i : '0;

    // Only one responder answers a request
    a_one_responder: assert property (@(posedge clk) disable iff (!rst_n)
        !(unmapped_ack_q && clint_ack_i))
        else $error("unmapped and CLINT ack high together");

endmodule

// File: clint.sv
// Core-local interruptor timer
`timescale 1ns/1ps
`include "clint_defs.svh"

module clint (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clint_sel_i,
    input  logic                     dbus_cyc_i,
    input  logic                     dbus_w_en_i,
    input  clint_pkg::type_dbus_addr_u dbus_addr_i,
    input  logic [`XLEN-1:0]         dbus_w_data_i,
    input  logic                     time_tick_i,
    output logic                     clint_ack_o,
    output logic [`XLEN-1:0]         clint_r_data_o,
    output logic [`XLEN-1:0]         time_lo_o,
    output logic [`XLEN-1:0]         time_hi_o,
    output logic                     timer_irq_o
);

    import clint_pkg::*;

    type_clint_regs_e   reg_offset;
    logic               r_req;
    logic               w_req;
    logic               req_new;
    logic [`XLEN-1:0]   r_data;
    logic               mtime_lo_wr;
    logic               mtime_hi_wr;
    logic               mtimecmp_lo_wr;
    logic               mtimecmp_hi_wr;
    logic [63:0]        mtime_q;
    logic [63:0]        mtime_next;
    logic [63:0]        mtimecmp_q;
    logic [63:0]        mtimecmp_next;
    logic               cmp_ge;
    logic               irq_q;
    logic               ack_q;
    logic [`XLEN-1:0]   r_data_q;

    // --------------------
    // Request decode
    // --------------------

    // Offset view of the address union
    assign reg_offset = type_clint_regs_e'(dbus_addr_i.field.offset);
    assign r_req      = dbus_cyc_i && clint_sel_i && !dbus_w_en_i;
    assign w_req      = dbus_cyc_i && clint_sel_i && dbus_w_en_i;

    // A held request is blocked by its own ack
    assign req_new = (r_req || w_req) && !ack_q;

    // Unknown offsets read as zero
    always_comb begin
        case (reg_offset)
            MTIME_LOW_R:     r_data = mtime_q[31:0];
            MTIME_HIGH_R:    r_data = mtime_q[63:32];
            MTIMECMP_LOW_R:  r_data = mtimecmp_q[31:0];
            MTIMECMP_HIGH_R: r_data = mtimecmp_q[63:32];
            default:         r_data = '0;
        endcase
    end

    // Per-half write flags set once per request
    always_comb begin
        mtime_lo_wr    = 1'b0;
        mtime_hi_wr    = 1'b0;
        mtimecmp_lo_wr = 1'b0;
        mtimecmp_hi_wr = 1'b0;
        if (w_req && !ack_q) begin
            case (reg_offset)
                MTIME_LOW_R:     mtime_lo_wr    = 1'b1;
                MTIME_HIGH_R:    mtime_hi_wr    = 1'b1;
                MTIMECMP_LOW_R:  mtimecmp_lo_wr = 1'b1;
                MTIMECMP_HIGH_R: mtimecmp_hi_wr = 1'b1;
                default:         ;
            endcase
        end
    end

    // --------------------
    // Timer registers
    // --------------------

    // Write replaces one half and wins over the tick
    always_comb begin
        mtime_next = mtime_q;
        if (mtime_lo_wr) begin
            mtime_next[31:0] = dbus_w_data_i;
        end else if (mtime_hi_wr) begin
            mtime_next[63:32] = dbus_w_data_i;
        end else if (time_tick_i) begin
            mtime_next = mtime_q + 64'd1;
        end
    end

    always_comb begin
        mtimecmp_next = mtimecmp_q;
        if (mtimecmp_lo_wr) begin
            mtimecmp_next[31:0] = dbus_w_data_i;
        end else if (mtimecmp_hi_wr) begin
            mtimecmp_next[63:32] = dbus_w_data_i;
        end
    end

    // Interrupt while mtime has reached mtimecmp
    assign cmp_ge = (mtime_q >= mtimecmp_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '0;
            irq_q      <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            mtime_q    <= mtime_next;
            mtimecmp_q <= mtimecmp_next;
            irq_q      <= cmp_ge;
            ack_q      <= req_new;
        end
    end

    // Read data is zero except on a read ack
    always_ff @(posedge clk) begin
        r_data_q <= (req_new && r_req) ? r_data : '0;
    end

    // --------------------
    // Outputs
    // --------------------

    assign clint_ack_o    = ack_q;
    assign clint_r_data_o = r_data_q;
    assign time_lo_o      = mtime_q[31:0];
    assign time_hi_o      = mtime_q[63:32];
    assign timer_irq_o    = irq_q;

    // Held request served once
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        clint_ack_o |=> !clint_ack_o)
        else $error("clint ack high in two consecutive cycles");

    // Without a register write the compare stays true
    a_cmp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cmp_ge && !(mtime_lo_wr || mtime_hi_wr || mtimecmp_lo_wr || mtimecmp_hi_wr))
        |=> cmp_ge)
        else $error("mtime compare dropped without a register write");

endmodule

// File: timer_prescaler.sv
// mtime tick prescaler
`timescale 1ns/1ps
`include "clint_defs.svh"

module timer_prescaler (
    input  logic clk,
    input  logic rst_n,
    output logic time_tick_o
);

    // Counter wide enough to hold CLINT_PRESCALE-1
    localparam int CNT_W = $clog2(`CLINT_PRESCALE);

    logic [CNT_W-1:0] count_q;
    logic             tick_q;

    // --------------------
    // Down-counter
    // --------------------

    // Reload at zero, one tick per CLINT_PRESCALE clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            tick_q  <= 1'b0;
        end else begin
            tick_q <= (count_q == '0);
            if (count_q == '0) begin
                count_q <= CNT_W'(`CLINT_PRESCALE - 1);
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Registered tick, a clock enable for mtime
    assign time_tick_o = tick_q;

    // Tick is a single-cycle pulse
    a_tick_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        time_tick_o |=> !time_tick_o)
        else $error("time_tick_o high in two consecutive cycles");

endmodule

// File: clint_pkg.sv
// CLINT subsystem types
`include "clint_defs.svh"

package clint_pkg;

    // --------------------
    // Bus address views
    // --------------------

    // Region and offset split of one bus address
    typedef struct packed {
        // Upper bits select the peripheral
        logic [`REGION_WIDTH-1:0]     region;
        // Lower bits select the register
        logic [`CLINT_ADDR_WIDTH-1:0] offset;
    } type_dbus_addr_fields_s;

    // Raw word for the master, field view for decoder and CLINT
    typedef union packed {
        logic [`BUS_ADDR_WIDTH-1:0] word;
        type_dbus_addr_fields_s     field;
    } type_dbus_addr_u;

    // --------------------
    // CLINT register map
    // --------------------

    // Byte offsets of the 32-bit timer registers
    typedef enum logic [`CLINT_ADDR_WIDTH-1:0] {
        MTIME_LOW_R     = 4'd0,
        MTIME_HIGH_R    = 4'd4,
        MTIMECMP_LOW_R  = 4'd8,
        MTIMECMP_HIGH_R = 4'd12
    } type_clint_regs_e;

endpackage

// File: clint_defs.svh
// CLINT subsystem parameters
`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// --------------------
// Bus widths
// --------------------

// Data word width
`define XLEN 32

// Full data-bus address width
`define BUS_ADDR_WIDTH 32

// --------------------
// Address split
// --------------------

// Register offset inside a region
`define CLINT_ADDR_WIDTH 4

// Region field above the offset
// REGION_WIDTH + CLINT_ADDR_WIDTH must equal BUS_ADDR_WIDTH
`define REGION_WIDTH 28

// Region code of the CLINT, base address 0x0200_0000
`define REGION_CLINT 28'h0200000

// --------------------
// Timer
// --------------------

// Clocks per mtime tick, at least 2
`define CLINT_PRESCALE 64

`endif
